//--- logic/tile_net_settings.svh
// tile network interface settings
`ifndef TILE_NET_SETTINGS_SVH
`define TILE_NET_SETTINGS_SVH

`define TN_DATA_W       32
`define TN_EVA_W        32
`define TN_EPA_W        16
`define TN_POD_W        2
`define TN_SUB_W        2
// pod bits followed by sub bits
`define TN_CORD_W       4
`define TN_REG_W        5
`define TN_MASK_W       4

`define TN_RET_DEPTH    4
`define TN_MAX_CREDITS  8
`define TN_CREDIT_W     4

`endif

//--- logic/tile_net_pkg.sv
// tile network interface types
package tile_net_pkg;

  typedef enum logic [1:0] {
    e_req_load,
    e_req_store,
    e_req_amoswap,
    e_req_amoor
  } req_op_e;

  typedef enum logic [1:0] {
    e_remote_load,
    e_remote_store,
    e_remote_amoswap,
    e_remote_amoor
  } net_op_e;

  // credit returns go to the counter, never to the fifo
  typedef enum logic [1:0] {
    e_return_ifetch,
    e_return_int_wb,
    e_return_float_wb,
    e_return_credit
  } ret_type_e;

  typedef enum logic [1:0] {
    e_region_dram,
    e_region_global,
    e_region_group,
    e_region_none
  } eva_region_e;

endpackage

//--- logic/eva_to_npa.sv
// eva to network address translation
`include "tile_net_settings.svh"

module eva_to_npa (
  input  logic [`TN_EVA_W-1:0]      eva_i,
  input  logic                      dram_enable_i,
  input  logic [`TN_SUB_W-1:0]      tgo_x_i,
  input  logic [`TN_SUB_W-1:0]      tgo_y_i,
  input  logic [`TN_POD_W-1:0]      pod_x_i,
  input  logic [`TN_POD_W-1:0]      pod_y_i,
  output logic [`TN_CORD_W-1:0]     x_cord_o,
  output logic [`TN_CORD_W-1:0]     y_cord_o,
  output logic [`TN_EPA_W-1:0]      epa_o,
  output tile_net_pkg::eva_region_e region_o,
  output logic                      invalid_o
);

  // tile in pod, offset by the tile group origin, wraps mod 4
  logic [`TN_SUB_W-1:0] group_x;
  logic [`TN_SUB_W-1:0] group_y;

  assign group_x = tgo_x_i + eva_i[19:18];
  assign group_y = tgo_y_i + eva_i[21:20];

  always_comb begin
    if (eva_i[31]) begin
      region_o = tile_net_pkg::e_region_dram;
    end else if (eva_i[30]) begin
      region_o = tile_net_pkg::e_region_global;
    end else if (eva_i[29]) begin
      region_o = tile_net_pkg::e_region_group;
    end else begin
      region_o = tile_net_pkg::e_region_none;
    end
  end

  assign invalid_o = (region_o == tile_net_pkg::e_region_none)
                   | ((region_o == tile_net_pkg::e_region_dram) & ~dram_enable_i);

  always_comb begin
    x_cord_o = '0;
    y_cord_o = '0;
    epa_o    = eva_i[17:2];
    case (region_o)
      tile_net_pkg::e_region_dram: begin
        // EVA[5:4] picks the cache column, bits above 19 fall off the epa
        x_cord_o = {pod_x_i, eva_i[5:4]};
        y_cord_o = '1;
        epa_o    = {eva_i[19:6], eva_i[3:2]};
      end
      tile_net_pkg::e_region_global: begin
        x_cord_o = eva_i[21:18];
        y_cord_o = eva_i[25:22];
      end
      tile_net_pkg::e_region_group: begin
        x_cord_o = {pod_x_i, group_x};
        y_cord_o = {pod_y_i, group_y};
      end
      default: begin
        epa_o = '0;
      end
    endcase
  end

endmodule

//--- logic/network_tx.sv
// remote request packet builder and response steering
`include "tile_net_settings.svh"

module network_tx (
  // request side
  input  logic                      req_v_i,
  input  tile_net_pkg::req_op_e     req_op_i,
  input  logic [`TN_DATA_W-1:0]     req_data_i,
  input  logic [`TN_MASK_W-1:0]     req_mask_i,
  input  logic [`TN_REG_W-1:0]      req_reg_id_i,
  input  logic [`TN_CORD_W-1:0]     x_cord_i,
  input  logic [`TN_CORD_W-1:0]     y_cord_i,
  input  logic [`TN_EPA_W-1:0]      epa_i,
  input  logic                      addr_invalid_i,
  input  logic [`TN_SUB_W-1:0]      my_x_i,
  input  logic [`TN_SUB_W-1:0]      my_y_i,
  input  logic [`TN_POD_W-1:0]      pod_x_i,
  input  logic [`TN_POD_W-1:0]      pod_y_i,
  // outgoing packet
  output logic                      out_v_o,
  output logic [`TN_CORD_W-1:0]     out_x_o,
  output logic [`TN_CORD_W-1:0]     out_y_o,
  output logic [`TN_CORD_W-1:0]     out_src_x_o,
  output logic [`TN_CORD_W-1:0]     out_src_y_o,
  output logic [`TN_EPA_W-1:0]      out_epa_o,
  output tile_net_pkg::net_op_e     out_op_o,
  output logic [`TN_DATA_W-1:0]     out_payload_o,
  output logic [`TN_REG_W-1:0]      out_reg_id_o,
  output logic                      invalid_eva_o,
  // return fifo head
  input  logic                      head_v_i,
  input  tile_net_pkg::ret_type_e   head_type_i,
  input  logic [`TN_DATA_W-1:0]     head_data_i,
  input  logic [`TN_REG_W-1:0]      head_reg_id_i,
  input  logic                      fifo_full_i,
  input  logic                      int_yumi_i,
  input  logic                      float_yumi_i,
  // core consumers
  output logic                      deq_o,
  output logic                      ifetch_v_o,
  output logic [`TN_DATA_W-1:0]     ifetch_instr_o,
  output logic                      int_v_o,
  output logic [`TN_REG_W-1:0]      int_rd_o,
  output logic [`TN_DATA_W-1:0]     int_data_o,
  output logic                      int_force_o,
  output logic                      float_v_o,
  output logic [`TN_REG_W-1:0]      float_rd_o,
  output logic [`TN_DATA_W-1:0]     float_data_o,
  output logic                      float_force_o
);

  assign out_x_o     = x_cord_i;
  assign out_y_o     = y_cord_i;
  assign out_epa_o   = epa_i;
  assign out_src_x_o = {pod_x_i, my_x_i};
  assign out_src_y_o = {pod_y_i, my_y_i};

  // loads carry no data
  assign out_payload_o = (req_op_i == tile_net_pkg::e_req_load) ? '0 : req_data_i;

  // a store sends its byte mask in the reg id field
  assign out_reg_id_o = (req_op_i == tile_net_pkg::e_req_store)
                      ? {{(`TN_REG_W-`TN_MASK_W){1'b0}}, req_mask_i}
                      : req_reg_id_i;

  always_comb begin
    case (req_op_i)
      tile_net_pkg::e_req_store:   out_op_o = tile_net_pkg::e_remote_store;
      tile_net_pkg::e_req_amoswap: out_op_o = tile_net_pkg::e_remote_amoswap;
      tile_net_pkg::e_req_amoor:   out_op_o = tile_net_pkg::e_remote_amoor;
      default:                     out_op_o = tile_net_pkg::e_remote_load;
    endcase
  end

  assign out_v_o       = req_v_i & ~addr_invalid_i;
  assign invalid_eva_o = req_v_i & addr_invalid_i;

  assign ifetch_instr_o = head_data_i;
  assign int_data_o     = head_data_i;
  assign int_rd_o       = head_reg_id_i;
  assign float_data_o   = head_data_i;
  assign float_rd_o     = head_reg_id_i;

  always_comb begin
    deq_o         = 1'b0;
    ifetch_v_o    = 1'b0;
    int_v_o       = 1'b0;
    int_force_o   = 1'b0;
    float_v_o     = 1'b0;
    float_force_o = 1'b0;
    case (head_type_i)
      tile_net_pkg::e_return_ifetch: begin
        // fetch path always takes the word
        ifetch_v_o = head_v_i;
        deq_o      = head_v_i;
      end
      tile_net_pkg::e_return_int_wb: begin
        int_v_o     = head_v_i;
        int_force_o = head_v_i & fifo_full_i;
        deq_o       = head_v_i & (int_yumi_i | fifo_full_i);
      end
      tile_net_pkg::e_return_float_wb: begin
        float_v_o     = head_v_i;
        float_force_o = head_v_i & fifo_full_i;
        deq_o         = head_v_i & (float_yumi_i | fifo_full_i);
      end
      default: begin
        // stray credit entry is dropped
        deq_o = head_v_i;
      end
    endcase
  end

endmodule

//--- logic/return_fifo.sv
// returned packet buffer
`include "tile_net_settings.svh"

module return_fifo (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    enq_v_i,
  input  tile_net_pkg::ret_type_e enq_type_i,
  input  logic [`TN_DATA_W-1:0]   enq_data_i,
  input  logic [`TN_REG_W-1:0]    enq_reg_id_i,
  input  logic                    deq_i,
  output logic                    head_v_o,
  output tile_net_pkg::ret_type_e head_type_o,
  output logic [`TN_DATA_W-1:0]   head_data_o,
  output logic [`TN_REG_W-1:0]    head_reg_id_o,
  output logic                    full_o
);

  localparam int PTR_W = $clog2(`TN_RET_DEPTH);

  tile_net_pkg::ret_type_e type_mem [`TN_RET_DEPTH];
  logic [`TN_DATA_W-1:0]   data_mem [`TN_RET_DEPTH];
  logic [`TN_REG_W-1:0]    reg_mem  [`TN_RET_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_enq;
  logic             do_deq;

  assign head_v_o = (count != '0);
  assign full_o   = (count == (PTR_W+1)'(`TN_RET_DEPTH));
  assign do_enq   = enq_v_i & ~full_o;
  assign do_deq   = deq_i & head_v_o;

  assign head_type_o   = type_mem[rd_ptr];
  assign head_data_o   = data_mem[rd_ptr];
  assign head_reg_id_o = reg_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_enq) begin
      type_mem[wr_ptr] <= enq_type_i;
      data_mem[wr_ptr] <= enq_data_i;
      reg_mem[wr_ptr]  <= enq_reg_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= (wr_ptr == PTR_W'(`TN_RET_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == PTR_W'(`TN_RET_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous enq and deq leaves the count alone
      if (do_enq && !do_deq) begin
        count <= count + 1'b1;
      end else if (do_deq && !do_enq) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- logic/out_credit_counter.sv
// outstanding request credit counter
`include "tile_net_settings.svh"

module out_credit_counter (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     sent_i,
  input  logic                     credit_v_i,
  output logic [`TN_CREDIT_W-1:0]  credits_o,
  output logic                     req_credit_o
);

  localparam logic [`TN_CREDIT_W-1:0] MAX_CREDITS = `TN_CREDIT_W'(`TN_MAX_CREDITS);

  logic dec;
  logic inc;

  // send and return in one cycle cancel out
  assign dec = sent_i & ~credit_v_i & (credits_o != '0);
  assign inc = credit_v_i & ~sent_i & (credits_o != MAX_CREDITS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_o    <= MAX_CREDITS;
      req_credit_o <= 1'b0;
    end else begin
      if (dec) begin
        credits_o <= credits_o - 1'b1;
      end else if (inc) begin
        credits_o <= credits_o + 1'b1;
      end
      // hand the returned credit on to the core
      req_credit_o <= credit_v_i;
    end
  end

endmodule

//--- logic/tile_net_top.sv
// tile network interface top
`include "tile_net_settings.svh"

module tile_net_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // core requests
  input  logic                    req_v_i,
  input  tile_net_pkg::req_op_e   req_op_i,
  input  logic [`TN_EVA_W-1:0]    req_eva_i,
  input  logic [`TN_DATA_W-1:0]   req_data_i,
  input  logic [`TN_MASK_W-1:0]   req_mask_i,
  input  logic [`TN_REG_W-1:0]    req_reg_id_i,
  output logic [`TN_CREDIT_W-1:0] credits_o,
  output logic                    req_credit_o,
  output logic                    invalid_eva_o,
  // tile position
  input  logic                    dram_enable_i,
  input  logic [`TN_SUB_W-1:0]    tgo_x_i,
  input  logic [`TN_SUB_W-1:0]    tgo_y_i,
  input  logic [`TN_SUB_W-1:0]    my_x_i,
  input  logic [`TN_SUB_W-1:0]    my_y_i,
  input  logic [`TN_POD_W-1:0]    pod_x_i,
  input  logic [`TN_POD_W-1:0]    pod_y_i,
  // network out
  output logic                    out_v_o,
  output logic [`TN_CORD_W-1:0]   out_x_o,
  output logic [`TN_CORD_W-1:0]   out_y_o,
  output logic [`TN_CORD_W-1:0]   out_src_x_o,
  output logic [`TN_CORD_W-1:0]   out_src_y_o,
  output logic [`TN_EPA_W-1:0]    out_epa_o,
  output tile_net_pkg::net_op_e   out_op_o,
  output logic [`TN_DATA_W-1:0]   out_payload_o,
  output logic [`TN_REG_W-1:0]    out_reg_id_o,
  // network returns
  input  logic                    ret_v_i,
  input  tile_net_pkg::ret_type_e ret_type_i,
  input  logic [`TN_DATA_W-1:0]   ret_data_i,
  input  logic [`TN_REG_W-1:0]    ret_reg_id_i,
  input  logic                    ret_credit_v_i,
  output logic                    ret_ready_o,
  // core responses
  output logic                    ifetch_v_o,
  output logic [`TN_DATA_W-1:0]   ifetch_instr_o,
  output logic                    int_v_o,
  output logic [`TN_REG_W-1:0]    int_rd_o,
  output logic [`TN_DATA_W-1:0]   int_data_o,
  output logic                    int_force_o,
  input  logic                    int_yumi_i,
  output logic                    float_v_o,
  output logic [`TN_REG_W-1:0]    float_rd_o,
  output logic [`TN_DATA_W-1:0]   float_data_o,
  output logic                    float_force_o,
  input  logic                    float_yumi_i
);

  logic [`TN_CORD_W-1:0]   x_cord;
  logic [`TN_CORD_W-1:0]   y_cord;
  logic [`TN_EPA_W-1:0]    epa;
  logic                    addr_invalid;
  logic                    head_v;
  tile_net_pkg::ret_type_e head_type;
  logic [`TN_DATA_W-1:0]   head_data;
  logic [`TN_REG_W-1:0]    head_reg_id;
  logic                    fifo_full;
  logic                    deq;

  assign ret_ready_o = ~fifo_full;

  return_fifo ret_fifo0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .enq_v_i(ret_v_i), .enq_type_i(ret_type_i),
    .enq_data_i(ret_data_i), .enq_reg_id_i(ret_reg_id_i),
    .deq_i(deq),
    .head_v_o(head_v), .head_type_o(head_type),
    .head_data_o(head_data), .head_reg_id_o(head_reg_id),
    .full_o(fifo_full)
  );

  eva_to_npa eva2npa0 (
    .eva_i(req_eva_i), .dram_enable_i(dram_enable_i),
    .tgo_x_i(tgo_x_i), .tgo_y_i(tgo_y_i),
    .pod_x_i(pod_x_i), .pod_y_i(pod_y_i),
    .x_cord_o(x_cord), .y_cord_o(y_cord), .epa_o(epa),
    .region_o(),
    .invalid_o(addr_invalid)
  );

  network_tx tx0 (
    .req_v_i(req_v_i), .req_op_i(req_op_i), .req_data_i(req_data_i),
    .req_mask_i(req_mask_i), .req_reg_id_i(req_reg_id_i),
    .x_cord_i(x_cord), .y_cord_i(y_cord), .epa_i(epa),
    .addr_invalid_i(addr_invalid),
    .my_x_i(my_x_i), .my_y_i(my_y_i), .pod_x_i(pod_x_i), .pod_y_i(pod_y_i),
    .out_v_o(out_v_o), .out_x_o(out_x_o), .out_y_o(out_y_o),
    .out_src_x_o(out_src_x_o), .out_src_y_o(out_src_y_o),
    .out_epa_o(out_epa_o), .out_op_o(out_op_o),
    .out_payload_o(out_payload_o), .out_reg_id_o(out_reg_id_o),
    .invalid_eva_o(invalid_eva_o),
    .head_v_i(head_v), .head_type_i(head_type),
    .head_data_i(head_data), .head_reg_id_i(head_reg_id),
    .fifo_full_i(fifo_full),
    .int_yumi_i(int_yumi_i), .float_yumi_i(float_yumi_i),
    .deq_o(deq),
    .ifetch_v_o(ifetch_v_o), .ifetch_instr_o(ifetch_instr_o),
    .int_v_o(int_v_o), .int_rd_o(int_rd_o),
    .int_data_o(int_data_o), .int_force_o(int_force_o),
    .float_v_o(float_v_o), .float_rd_o(float_rd_o),
    .float_data_o(float_data_o), .float_force_o(float_force_o)
  );

  out_credit_counter credit0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .sent_i(out_v_o), .credit_v_i(ret_credit_v_i),
    .credits_o(credits_o), .req_credit_o(req_credit_o)
  );

endmodule

//--- dv/tile_net_properties.sv
// tile network interface assertions
`include "tile_net_settings.svh"

module tile_net_properties (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    head_v_i,
  input tile_net_pkg::ret_type_e head_type_i,
  input logic                    fifo_full_i,
  input logic                    deq_i,
  input logic                    out_v_i,
  input logic                    invalid_eva_i,
  input logic [`TN_CREDIT_W-1:0] credits_i
);
  timeunit 1ns;
  timeprecision 1ps;

  a_no_credit_head: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    head_v_i |-> head_type_i != tile_net_pkg::e_return_credit)
    else $error("credit packet reached the return fifo head");

  a_full_forces_deq: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (fifo_full_i && head_v_i) |-> deq_i)
    else $error("full return fifo did not dequeue its head");

  a_send_or_invalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(out_v_i && invalid_eva_i))
    else $error("packet sent for an invalid address");

  a_credit_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credits_i <= `TN_CREDIT_W'(`TN_MAX_CREDITS))
    else $error("credit count above its limit");

endmodule

// watches the return fifo head, the sender and the credit count
bind tile_net_top tile_net_properties props0 (
  .clk_i(clk_i),
  .arst_n_i(arst_n_i),
  .head_v_i(head_v),
  .head_type_i(head_type),
  .fifo_full_i(fifo_full),
  .deq_i(deq),
  .out_v_i(out_v_o),
  .invalid_eva_i(invalid_eva_o),
  .credits_i(credits_o)
);

//--- dv/tile_net_checker.sv
// tile network interface output checker
`include "tile_net_settings.svh"

module tile_net_checker (
  input  logic                    clk_i,
  input  logic                    chk_v_i,
  input  logic [7:0]              test_i,
  input  logic [31:0]             exp_i [15],
  input  logic [`TN_CORD_W-1:0]   exp_src_x_i,
  input  logic [`TN_CORD_W-1:0]   exp_src_y_i,
  input  logic                    out_v_i,
  input  logic                    invalid_eva_i,
  input  logic [`TN_CORD_W-1:0]   out_x_i,
  input  logic [`TN_CORD_W-1:0]   out_y_i,
  input  logic [`TN_CORD_W-1:0]   out_src_x_i,
  input  logic [`TN_CORD_W-1:0]   out_src_y_i,
  input  logic [`TN_EPA_W-1:0]    out_epa_i,
  input  logic [1:0]              out_op_i,
  input  logic [`TN_DATA_W-1:0]   out_payload_i,
  input  logic [`TN_REG_W-1:0]    out_reg_id_i,
  input  logic [`TN_CREDIT_W-1:0] credits_i,
  input  logic                    req_credit_i,
  input  logic                    ret_ready_i,
  input  logic                    ifetch_v_i,
  input  logic [`TN_DATA_W-1:0]   ifetch_instr_i,
  input  logic                    int_v_i,
  input  logic [`TN_REG_W-1:0]    int_rd_i,
  input  logic [`TN_DATA_W-1:0]   int_data_i,
  input  logic                    int_force_i,
  input  logic                    float_v_i,
  input  logic [`TN_REG_W-1:0]    float_rd_i,
  input  logic [`TN_DATA_W-1:0]   float_data_i,
  input  logic                    float_force_i,
  output int                      pass_cnt_o,
  output int                      fail_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int passed = 0;
  int failed = 0;
  int errs = 0;
  logic [7:0] cur_test = '0;

  assign pass_cnt_o = passed;
  assign fail_cnt_o = failed;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] test %0d %s: got %h expected %h", cur_test, name, got, exp);
      errs++;
    end
  endtask

  // expected fields in order v inv x y epa op payload reg credits rcredit ready resp force rdata rd
  always @(negedge clk_i) begin
    if (test_i != cur_test) begin
      if (cur_test != 0) begin
        if (errs == 0) begin
          passed++;
          $display("test %0d passed", cur_test);
        end else begin
          failed++;
          $display("test %0d failed with %0d errors", cur_test, errs);
        end
      end
      cur_test = test_i;
      errs = 0;
    end
    if (chk_v_i) begin
      compare("out_v_o", out_v_i, exp_i[0]);
      compare("invalid_eva_o", invalid_eva_i, exp_i[1]);
      if (exp_i[0][0]) begin
        compare("out_x_o", out_x_i, exp_i[2]);
        compare("out_y_o", out_y_i, exp_i[3]);
        compare("out_epa_o", out_epa_i, exp_i[4]);
        compare("out_op_o", out_op_i, exp_i[5]);
        compare("out_payload_o", out_payload_i, exp_i[6]);
        compare("out_reg_id_o", out_reg_id_i, exp_i[7]);
        // source is always this tile
        compare("out_src_x_o", out_src_x_i, exp_src_x_i);
        compare("out_src_y_o", out_src_y_i, exp_src_y_i);
      end
      compare("credits_o", credits_i, exp_i[8]);
      compare("req_credit_o", req_credit_i, exp_i[9]);
      compare("ret_ready_o", ret_ready_i, exp_i[10]);
      compare("ifetch_v_o", ifetch_v_i, exp_i[11][0]);
      compare("int_v_o", int_v_i, exp_i[11][1]);
      compare("float_v_o", float_v_i, exp_i[11][2]);
      compare("int_force_o", int_force_i, exp_i[12][0] & exp_i[11][1]);
      compare("float_force_o", float_force_i, exp_i[12][0] & exp_i[11][2]);
      if (exp_i[11][0]) compare("ifetch_instr_o", ifetch_instr_i, exp_i[13]);
      if (exp_i[11][1]) begin
        compare("int_data_o", int_data_i, exp_i[13]);
        compare("int_rd_o", int_rd_i, exp_i[14]);
      end
      if (exp_i[11][2]) begin
        compare("float_data_o", float_data_i, exp_i[13]);
        compare("float_rd_o", float_rd_i, exp_i[14]);
      end
    end
  end

endmodule

//--- dv/tile_net_tb.sv
// tile network interface testbench
`include "tile_net_settings.svh"

module tile_net_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_REC = 64;

  logic clk;
  logic arst_n;
  logic req_v;
  tile_net_pkg::req_op_e req_op;
  logic [31:0] req_eva;
  logic [31:0] req_data;
  logic [3:0] req_mask;
  logic [4:0] req_reg_id;
  logic dram_enable;
  logic ret_v;
  tile_net_pkg::ret_type_e ret_type;
  logic [31:0] ret_data;
  logic [4:0] ret_reg_id;
  logic ret_credit_v;
  logic int_yumi;
  logic float_yumi;
  logic chk_v;
  logic [7:0] test_id;
  logic [31:0] exp_cur [15];
  logic [31:0] rec [MAX_REC][24];
  int n_rec;
  int cycles;
  int limit;
  int pass_cnt;
  int fail_cnt;

  logic out_v, invalid_eva, req_credit, ret_ready, ifetch_v, int_v, int_force;
  logic float_v, float_force;
  logic [3:0] out_x, out_y, out_src_x, out_src_y, credits;
  logic [15:0] out_epa;
  tile_net_pkg::net_op_e out_op;
  logic [31:0] out_payload, ifetch_instr, int_data, float_data;
  logic [4:0] out_reg_id, int_rd, float_rd;

  tile_net_top dut0 (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_v_i(req_v), .req_op_i(req_op), .req_eva_i(req_eva), .req_data_i(req_data),
    .req_mask_i(req_mask), .req_reg_id_i(req_reg_id),
    .credits_o(credits), .req_credit_o(req_credit), .invalid_eva_o(invalid_eva),
    .dram_enable_i(dram_enable), .tgo_x_i(2'd1), .tgo_y_i(2'd2),
    .my_x_i(2'd3), .my_y_i(2'd1), .pod_x_i(2'd1), .pod_y_i(2'd2),
    .out_v_o(out_v), .out_x_o(out_x), .out_y_o(out_y),
    .out_src_x_o(out_src_x), .out_src_y_o(out_src_y), .out_epa_o(out_epa),
    .out_op_o(out_op), .out_payload_o(out_payload), .out_reg_id_o(out_reg_id),
    .ret_v_i(ret_v), .ret_type_i(ret_type), .ret_data_i(ret_data),
    .ret_reg_id_i(ret_reg_id), .ret_credit_v_i(ret_credit_v), .ret_ready_o(ret_ready),
    .ifetch_v_o(ifetch_v), .ifetch_instr_o(ifetch_instr),
    .int_v_o(int_v), .int_rd_o(int_rd), .int_data_o(int_data),
    .int_force_o(int_force), .int_yumi_i(int_yumi),
    .float_v_o(float_v), .float_rd_o(float_rd), .float_data_o(float_data),
    .float_force_o(float_force), .float_yumi_i(float_yumi)
  );

  // this tile is column 3 of pod 1 and row 1 of pod 2
  tile_net_checker checker0 (
    .clk_i(clk), .chk_v_i(chk_v), .test_i(test_id), .exp_i(exp_cur),
    .exp_src_x_i(4'h7), .exp_src_y_i(4'h9),
    .out_v_i(out_v), .invalid_eva_i(invalid_eva), .out_x_i(out_x), .out_y_i(out_y),
    .out_src_x_i(out_src_x), .out_src_y_i(out_src_y), .out_epa_i(out_epa),
    .out_op_i(out_op), .out_payload_i(out_payload), .out_reg_id_i(out_reg_id),
    .credits_i(credits), .req_credit_i(req_credit), .ret_ready_i(ret_ready),
    .ifetch_v_i(ifetch_v), .ifetch_instr_i(ifetch_instr),
    .int_v_i(int_v), .int_rd_i(int_rd), .int_data_i(int_data), .int_force_i(int_force),
    .float_v_i(float_v), .float_rd_i(float_rd), .float_data_i(float_data),
    .float_force_i(float_force), .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic read_trace();
    int fd;
    int n;
    string line;
    logic [31:0] f [24];
    n_rec = 0;
    fd = $fopen("dv/tile_net_trace.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && n_rec < MAX_REC) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
          f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23]);
        if (n == 24) begin
          rec[n_rec] = f;
          n_rec++;
        end
      end
    end
    $fclose(fd);
  endtask

  // kind 0 idle, 1 request, 2 return, 3 credit
  task automatic apply(input int i);
    test_id <= rec[i][0][7:0];
    req_v <= (rec[i][1] == 1);
    ret_v <= (rec[i][1] == 2);
    ret_credit_v <= (rec[i][1] == 3);
    dram_enable <= rec[i][2][0];
    req_op <= tile_net_pkg::req_op_e'(rec[i][3][1:0]);
    req_mask <= rec[i][4][3:0];
    ret_type <= tile_net_pkg::ret_type_e'(rec[i][4][1:0]);
    req_eva <= rec[i][5];
    req_data <= rec[i][6];
    ret_data <= rec[i][6];
    req_reg_id <= rec[i][7][4:0];
    ret_reg_id <= rec[i][7][4:0];
    int_yumi <= rec[i][8][0];
    float_yumi <= rec[i][8][1];
    chk_v <= 1'b1;
    for (int j = 0; j < 15; j++) begin
      exp_cur[j] <= rec[i][9+j];
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run passed its limit of %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    arst_n = 1'b0;
    req_v = 1'b0;
    req_op = tile_net_pkg::e_req_load;
    req_eva = '0;
    req_data = '0;
    req_mask = '0;
    req_reg_id = '0;
    dram_enable = 1'b0;
    ret_v = 1'b0;
    ret_type = tile_net_pkg::e_return_ifetch;
    ret_data = '0;
    ret_reg_id = '0;
    ret_credit_v = 1'b0;
    int_yumi = 1'b0;
    float_yumi = 1'b0;
    chk_v = 1'b0;
    test_id = '0;
    cycles = 0;
    limit = 0;
    for (int j = 0; j < 15; j++) exp_cur[j] = '0;
    read_trace();
    limit = 4 * n_rec + 20;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < n_rec; i++) begin
      @(posedge clk);
      apply(i);
    end
    @(posedge clk);
    chk_v <= 1'b0;
    test_id <= '0;
    req_v <= 1'b0;
    ret_v <= 1'b0;
    ret_credit_v <= 1'b0;
    repeat (2) @(posedge clk);
    $display("tests: %0d passed, %0d failed, %0d trace records", pass_cnt, fail_cnt, n_rec);
    if (n_rec == 0) $display("no trace records could be read");
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- dv/tile_net_trace.txt
# test kind dram op aux eva data reg yumi | out_v inv x y epa op payload reg
# credits req_credit ready resp(1 ifetch 2 int 4 float) force rdata rd ; kind 0 idle 1 req 2 ret 3 credit
1 1 1 0 0 414c48d0 deadbeef 0a 0  1 0 3 5 1234 0 00000000 0a 8 0 1 0 0 00000000 00
1 1 1 0 0 20382af0 00000000 03 0  1 0 7 9 0abc 0 00000000 03 7 0 1 0 0 00000000 00
1 1 1 0 0 80012374 00000000 1f 0  1 0 7 f 1235 0 00000000 1f 6 0 1 0 0 00000000 00
2 1 1 0 0 10000000 00000000 00 0  0 1 0 0 0000 0 00000000 00 5 0 1 0 0 00000000 00
2 1 0 0 0 80012374 00000000 00 0  0 1 0 0 0000 0 00000000 00 5 0 1 0 0 00000000 00
3 1 1 1 a 414c48d0 11223344 1c 0  1 0 3 5 1234 1 11223344 0a 5 0 1 0 0 00000000 00
3 1 1 2 0 414c48d0 55667788 05 0  1 0 3 5 1234 2 55667788 05 4 0 1 0 0 00000000 00
3 1 1 3 0 414c48d0 99aabbcc 06 0  1 0 3 5 1234 3 99aabbcc 06 3 0 1 0 0 00000000 00
4 3 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 2 0 1 0 0 00000000 00
4 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 1 1 0 0 00000000 00
4 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 0 1 0 0 00000000 00
5 2 1 0 0 00000000 00000013 00 0  0 0 0 0 0000 0 00000000 00 3 0 1 0 0 00000000 00
5 2 1 0 1 00000000 cafe0001 07 0  0 0 0 0 0000 0 00000000 00 3 0 1 1 0 00000013 00
5 2 1 0 2 00000000 3f800000 02 0  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 cafe0001 07
5 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 cafe0001 07
5 0 1 0 0 00000000 00000000 00 1  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 cafe0001 07
5 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 0 1 4 0 3f800000 02
5 0 1 0 0 00000000 00000000 00 2  0 0 0 0 0000 0 00000000 00 3 0 1 4 0 3f800000 02
5 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 0 1 0 0 00000000 00
6 2 1 0 1 00000000 00000a01 01 0  0 0 0 0 0000 0 00000000 00 3 0 1 0 0 00000000 00
6 2 1 0 1 00000000 00000a02 02 0  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 00000a01 01
6 2 1 0 1 00000000 00000a03 03 0  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 00000a01 01
6 2 1 0 1 00000000 00000a04 04 0  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 00000a01 01
6 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 0 0 2 1 00000a01 01
6 0 1 0 0 00000000 00000000 00 0  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 00000a02 02
6 0 1 0 0 00000000 00000000 00 1  0 0 0 0 0000 0 00000000 00 3 0 1 2 0 00000a02 02

//--- verilog.f
+incdir+logic
logic/tile_net_pkg.sv
logic/eva_to_npa.sv
logic/network_tx.sv
logic/return_fifo.sv
logic/out_credit_counter.sv
logic/tile_net_top.sv
dv/tile_net_properties.sv
dv/tile_net_checker.sv
dv/tile_net_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the tile network interface simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tile_net_tb -f verilog.f -o tile_net_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tile_net_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "no pass result found in sim.log"
  exit 1
fi
exit 0
